//--- compile.f
hw/ooo_pkg.sv
hw/free_list.sv
hw/spec_rat.sv
hw/rename_stage.sv
hw/rob.sv
hw/rename_retire_top.sv
verification/tb_clock_gen.sv
verification/tb_rename_retire.sv

//--- hw/free_list.sv
`timescale 1ns/1ps

module free_list import ooo_pkg::*; (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              alloc_req0,
    input  logic              alloc_req1,
    input  logic              release_valid0,
    input  logic [preg_w-1:0] release_prd0,
    input  logic              walk_release0,
    input  logic [preg_w-1:0] walk_prd0,
    input  logic              walk_release1,
    input  logic [preg_w-1:0] walk_prd1,
    output logic [preg_w-1:0] grant_prd0,
    output logic [preg_w-1:0] grant_prd1,
    output logic [preg_w:0]   fl_free_cnt
);

    // one bit per physical register, set means free
    logic [num_preg-1:0] free_vec;
    logic [preg_w-1:0]   first_prd;
    logic [preg_w-1:0]   second_prd;
    logic [1:0]          alloc_n;
    logic [1:0]          rel_n;

    // --------------------------------------------------
    // lowest and next-lowest free register
    // --------------------------------------------------
    always_comb begin
        logic found_first;
        logic found_second;
        found_first  = 1'b0;
        found_second = 1'b0;
        first_prd    = '0;
        second_prd   = '0;
        for (int i = 0; i < num_preg; i++) begin
            if (free_vec[i] && found_first && !found_second) begin
                second_prd   = preg_w'(i);
                found_second = 1'b1;
            end
            if (free_vec[i] && !found_first) begin
                first_prd   = preg_w'(i);
                found_first = 1'b1;
            end
        end
    end

    // lone slot 1 writer still gets the lowest
    assign grant_prd0 = first_prd;
    assign grant_prd1 = alloc_req0 ? second_prd : first_prd;

    assign alloc_n = {1'b0, alloc_req0} + {1'b0, alloc_req1};
    assign rel_n   = {1'b0, release_valid0} + {1'b0, walk_release0} + {1'b0, walk_release1};

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            // upper half free, lower half holds the identity map
            free_vec    <= {{(num_preg - num_lreg){1'b1}}, {num_lreg{1'b0}}};
            fl_free_cnt <= (preg_w + 1)'(num_preg - num_lreg);
        end else begin
            if (alloc_req0)     free_vec[grant_prd0]   <= 1'b0;
            if (alloc_req1)     free_vec[grant_prd1]   <= 1'b0;
            if (release_valid0) free_vec[release_prd0] <= 1'b1;
            if (walk_release0)  free_vec[walk_prd0]    <= 1'b1;
            if (walk_release1)  free_vec[walk_prd1]    <= 1'b1;
            fl_free_cnt <= fl_free_cnt - (preg_w + 1)'(alloc_n) + (preg_w + 1)'(rel_n);
        end
    end

    // a commit or walk release must hand back a register that is in use
    assert property (@(posedge clock) disable iff (!reset_n)
        release_valid0 |-> !free_vec[release_prd0]);
    assert property (@(posedge clock) disable iff (!reset_n)
        (walk_release0 |-> !free_vec[walk_prd0]) and (walk_release1 |-> !free_vec[walk_prd1]));

endmodule

//--- hw/ooo_pkg.sv
package ooo_pkg;

    // --------------------------------------------------
    // register file sizes
    // --------------------------------------------------

    // architectural registers seen by software
    localparam int num_lreg = 32;
    localparam int lreg_w   = 5;

    // physical registers behind the rename map
    localparam int num_preg = 64;
    localparam int preg_w   = 6;

    // --------------------------------------------------
    // reorder buffer sizes
    // --------------------------------------------------

    localparam int rob_depth  = 64;
    localparam int rob_addr_w = 6;
    // entry index plus one wrap bit
    localparam int rob_id_w   = 7;

    // --------------------------------------------------
    // flush state encodings
    // --------------------------------------------------

    // normal operation, dispatch allowed
    localparam logic [1:0] walk_idle     = 2'd0;
    // one cycle, squash younger entries
    localparam logic [1:0] walk_rollback = 2'd1;
    // undo renames, two entries per cycle
    localparam logic [1:0] walk_walk     = 2'd2;

endpackage

//--- hw/rename_retire_top.sv
`timescale 1ns/1ps

module rename_retire_top import ooo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  disp_valid0,
    input  logic                  disp_valid1,
    input  logic [lreg_w-1:0]     disp_lrd0,
    input  logic [lreg_w-1:0]     disp_lrd1,
    input  logic                  disp_need_to_wb0,
    input  logic                  disp_need_to_wb1,
    input  logic                  complete_wren0,
    input  logic [rob_addr_w-1:0] complete_wraddr0,
    input  logic                  complete_wren1,
    input  logic [rob_addr_w-1:0] complete_wraddr1,
    input  logic                  flush_valid,
    input  logic [rob_id_w-1:0]   flush_id,
    output logic                  dispatch_ready,
    output logic                  commit_valid,
    output logic                  commit_need_to_wb,
    output logic [lreg_w-1:0]     commit_lrd,
    output logic [preg_w-1:0]     commit_prd,
    output logic [preg_w-1:0]     commit_old_prd,
    output logic [rob_id_w-1:0]   rob_instr_cnt,
    output logic [rob_id_w-1:0]   rob_instr_id,
    output logic                  is_idle
);

    // --------------------------------------------------
    // interconnect
    // --------------------------------------------------
    logic                alloc_req0, alloc_req1;
    logic [preg_w-1:0]   grant_prd0, grant_prd1;
    logic [preg_w:0]     fl_free_cnt;
    logic [rob_id_w-1:0] rob_free_cnt;
    logic [lreg_w-1:0]   map_lrd0, map_lrd1;
    logic [preg_w-1:0]   map_prd0, map_prd1;
    logic                rename_wen0, rename_wen1;
    logic                enq_valid0, enq_valid1, enq_need_to_wb0, enq_need_to_wb1;
    logic [lreg_w-1:0]   enq_lrd0, enq_lrd1;
    logic [preg_w-1:0]   enq_prd0, enq_prd1, enq_old_prd0, enq_old_prd1;
    logic                walking_valid0, walking_valid1;
    logic [lreg_w-1:0]   walking_lrd0, walking_lrd1;
    logic [preg_w-1:0]   walking_prd0, walking_prd1, walking_old_prd0, walking_old_prd1;

    // dispatch held off while the rob runs a flush
    rename_stage rename_stage_inst (.*, .rob_idle(is_idle));

    // retired writer hands back the mapping it replaced
    free_list free_list_inst (
        .clock, .reset_n, .alloc_req0, .alloc_req1,
        .release_valid0(commit_valid && commit_need_to_wb), .release_prd0(commit_old_prd),
        .walk_release0(walking_valid0), .walk_prd0(walking_prd0),
        .walk_release1(walking_valid1), .walk_prd1(walking_prd1),
        .grant_prd0, .grant_prd1, .fl_free_cnt);

    // walk restores the squashed entries' old mappings
    spec_rat spec_rat_inst (
        .clock, .reset_n, .map_lrd0, .map_lrd1, .rename_wen0, .rename_wen1,
        .rename_prd0(grant_prd0), .rename_prd1(grant_prd1),
        .walk_wen0(walking_valid0), .walk_lrd0(walking_lrd0), .walk_old_prd0(walking_old_prd0),
        .walk_wen1(walking_valid1), .walk_lrd1(walking_lrd1), .walk_old_prd1(walking_old_prd1),
        .map_prd0, .map_prd1);

    rob rob_inst (.*);

endmodule

//--- hw/rename_stage.sv
`timescale 1ns/1ps

module rename_stage import ooo_pkg::*; (
    input  logic                disp_valid0,
    input  logic                disp_valid1,
    input  logic [lreg_w-1:0]   disp_lrd0,
    input  logic [lreg_w-1:0]   disp_lrd1,
    input  logic                disp_need_to_wb0,
    input  logic                disp_need_to_wb1,
    input  logic [rob_id_w-1:0] rob_free_cnt,
    input  logic                rob_idle,
    input  logic [preg_w:0]     fl_free_cnt,
    input  logic [preg_w-1:0]   grant_prd0,
    input  logic [preg_w-1:0]   grant_prd1,
    input  logic [preg_w-1:0]   map_prd0,
    input  logic [preg_w-1:0]   map_prd1,
    output logic                dispatch_ready,
    output logic                alloc_req0,
    output logic                alloc_req1,
    output logic [lreg_w-1:0]   map_lrd0,
    output logic [lreg_w-1:0]   map_lrd1,
    output logic                rename_wen0,
    output logic                rename_wen1,
    output logic                enq_valid0,
    output logic                enq_valid1,
    output logic [lreg_w-1:0]   enq_lrd0,
    output logic [lreg_w-1:0]   enq_lrd1,
    output logic [preg_w-1:0]   enq_prd0,
    output logic [preg_w-1:0]   enq_prd1,
    output logic [preg_w-1:0]   enq_old_prd0,
    output logic [preg_w-1:0]   enq_old_prd1,
    output logic                enq_need_to_wb0,
    output logic                enq_need_to_wb1
);

    // room for a full pair in both rob and free list, and no flush running
    assign dispatch_ready = rob_idle && (rob_free_cnt >= rob_id_w'(2))
                            && (fl_free_cnt >= (preg_w + 1)'(2));

    // pair dropped as a whole when not ready
    assign enq_valid0 = dispatch_ready && disp_valid0;
    assign enq_valid1 = dispatch_ready && disp_valid0 && disp_valid1;

    // only writers take a new register
    assign alloc_req0  = enq_valid0 && disp_need_to_wb0;
    assign alloc_req1  = enq_valid1 && disp_need_to_wb1;
    assign rename_wen0 = alloc_req0;
    assign rename_wen1 = alloc_req1;

    // previous mappings from the speculative map
    assign map_lrd0 = disp_lrd0;
    assign map_lrd1 = disp_lrd1;

    assign enq_lrd0        = disp_lrd0;
    assign enq_lrd1        = disp_lrd1;
    assign enq_prd0        = grant_prd0;
    assign enq_prd1        = grant_prd1;
    assign enq_need_to_wb0 = disp_need_to_wb0;
    assign enq_need_to_wb1 = disp_need_to_wb1;
    assign enq_old_prd0    = map_prd0;
    // slot 0 renamed the same lrd this cycle, map not yet updated
    assign enq_old_prd1    = (alloc_req0 && (disp_lrd0 == disp_lrd1)) ? grant_prd0 : map_prd1;

    // dispatch pairs are packed toward slot 0
    always_comb begin
        assert (!disp_valid1 || disp_valid0)
            else $error("rename_stage: slot 1 valid without slot 0");
    end

endmodule

//--- hw/rob.sv
`timescale 1ns/1ps

module rob import ooo_pkg::*; (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  enq_valid0,
    input  logic                  enq_valid1,
    input  logic [lreg_w-1:0]     enq_lrd0,
    input  logic [lreg_w-1:0]     enq_lrd1,
    input  logic [preg_w-1:0]     enq_prd0,
    input  logic [preg_w-1:0]     enq_prd1,
    input  logic [preg_w-1:0]     enq_old_prd0,
    input  logic [preg_w-1:0]     enq_old_prd1,
    input  logic                  enq_need_to_wb0,
    input  logic                  enq_need_to_wb1,
    input  logic                  complete_wren0,
    input  logic [rob_addr_w-1:0] complete_wraddr0,
    input  logic                  complete_wren1,
    input  logic [rob_addr_w-1:0] complete_wraddr1,
    input  logic                  flush_valid,
    input  logic [rob_id_w-1:0]   flush_id,
    output logic [rob_id_w-1:0]   rob_free_cnt,
    output logic [rob_id_w-1:0]   rob_instr_cnt,
    output logic [rob_id_w-1:0]   rob_instr_id,
    output logic                  is_idle,
    output logic                  commit_valid,
    output logic                  commit_need_to_wb,
    output logic [lreg_w-1:0]     commit_lrd,
    output logic [preg_w-1:0]     commit_prd,
    output logic [preg_w-1:0]     commit_old_prd,
    output logic                  walking_valid0,
    output logic                  walking_valid1,
    output logic [lreg_w-1:0]     walking_lrd0,
    output logic [lreg_w-1:0]     walking_lrd1,
    output logic [preg_w-1:0]     walking_prd0,
    output logic [preg_w-1:0]     walking_prd1,
    output logic [preg_w-1:0]     walking_old_prd0,
    output logic [preg_w-1:0]     walking_old_prd1
);

    // entry payload
    logic [lreg_w-1:0]     entry_lrd        [rob_depth];
    logic [preg_w-1:0]     entry_prd        [rob_depth];
    logic [preg_w-1:0]     entry_old_prd    [rob_depth];
    logic                  entry_need_to_wb [rob_depth];
    // entry status
    logic [rob_depth-1:0]  entry_valid;
    logic [rob_depth-1:0]  entry_complete;

    logic [rob_addr_w-1:0] enq_ptr;
    logic [rob_addr_w-1:0] enq_ptr_p1;
    logic [rob_addr_w-1:0] deq_ptr;
    logic [rob_addr_w-1:0] walk_ptr;
    logic [rob_addr_w-1:0] walk_ptr_m1;
    logic [rob_addr_w-1:0] keep_idx;
    logic [rob_id_w-1:0]   walk_left;
    logic [rob_id_w-1:0]   flush_id_q;
    logic [rob_id_w-1:0]   squash_cnt;
    logic [rob_id_w-1:0]   head_id;
    logic [rob_depth-1:0]  squash_mask;
    logic [1:0]            state;
    logic [1:0]            enq_n;
    logic                  head_ready;

    assign enq_ptr_p1  = enq_ptr + rob_addr_w'(1);
    assign walk_ptr_m1 = walk_ptr - rob_addr_w'(1);
    assign enq_n       = {1'b0, enq_valid0} + {1'b0, enq_valid1};
    assign head_ready  = entry_valid[deq_ptr] && entry_complete[deq_ptr];
    assign head_id     = rob_instr_id - rob_instr_cnt;

    assign is_idle      = (state == walk_idle);
    assign rob_free_cnt = rob_id_w'(rob_depth) - rob_instr_cnt;

    // --------------------------------------------------
    // squash window, ids flush_id+1 up to instr_id-1
    // --------------------------------------------------
    assign squash_cnt = rob_instr_id - flush_id_q - rob_id_w'(1);
    assign keep_idx   = flush_id_q[rob_addr_w-1:0] + rob_addr_w'(1);

    always_comb begin
        logic [rob_addr_w-1:0] off;
        for (int i = 0; i < rob_depth; i++) begin
            off            = rob_addr_w'(i) - keep_idx;
            squash_mask[i] = ({1'b0, off} < squash_cnt);
        end
    end

    // --------------------------------------------------
    // control state
    // --------------------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state          <= walk_idle;
            flush_id_q     <= '0;
            enq_ptr        <= '0;
            deq_ptr        <= '0;
            walk_ptr       <= '0;
            walk_left      <= '0;
            rob_instr_id   <= '0;
            rob_instr_cnt  <= '0;
            entry_valid    <= '0;
            entry_complete <= '0;
            commit_valid   <= 1'b0;
        end else begin
            case (state)
                walk_idle: begin
                    if (flush_valid) begin
                        flush_id_q <= flush_id;
                        state      <= walk_rollback;
                    end
                    enq_ptr      <= enq_ptr + rob_addr_w'(enq_n);
                    rob_instr_id <= rob_instr_id + rob_id_w'(enq_n);
                end
                walk_rollback: begin
                    entry_valid  <= entry_valid & ~squash_mask;
                    enq_ptr      <= keep_idx;
                    rob_instr_id <= flush_id_q + rob_id_w'(1);
                    // walk starts at the youngest squashed entry
                    walk_ptr     <= enq_ptr - rob_addr_w'(1);
                    walk_left    <= squash_cnt;
                    state        <= walk_walk;
                end
                default: begin
                    walk_ptr  <= walk_ptr - rob_addr_w'(2);
                    walk_left <= (walk_left > rob_id_w'(2)) ? walk_left - rob_id_w'(2) : '0;
                    if (walk_left <= rob_id_w'(2)) begin
                        state <= walk_idle;
                    end
                end
            endcase
            rob_instr_cnt <= rob_instr_cnt + rob_id_w'(enq_n) - rob_id_w'(head_ready)
                             - ((state == walk_rollback) ? squash_cnt : '0);
            // new entries start incomplete
            if (enq_valid0) begin
                entry_valid[enq_ptr]    <= 1'b1;
                entry_complete[enq_ptr] <= 1'b0;
            end
            if (enq_valid1) begin
                entry_valid[enq_ptr_p1]    <= 1'b1;
                entry_complete[enq_ptr_p1] <= 1'b0;
            end
            if (complete_wren0) entry_complete[complete_wraddr0] <= 1'b1;
            if (complete_wren1) entry_complete[complete_wraddr1] <= 1'b1;
            // retire one per cycle, flush never reaches the head
            commit_valid <= head_ready;
            if (head_ready) begin
                entry_valid[deq_ptr] <= 1'b0;
                deq_ptr              <= deq_ptr + rob_addr_w'(1);
            end
        end
    end

    // payload arrays and commit data
    always_ff @(posedge clock) begin
        if (enq_valid0) begin
            entry_lrd[enq_ptr]        <= enq_lrd0;
            entry_prd[enq_ptr]        <= enq_prd0;
            entry_old_prd[enq_ptr]    <= enq_old_prd0;
            entry_need_to_wb[enq_ptr] <= enq_need_to_wb0;
        end
        if (enq_valid1) begin
            entry_lrd[enq_ptr_p1]        <= enq_lrd1;
            entry_prd[enq_ptr_p1]        <= enq_prd1;
            entry_old_prd[enq_ptr_p1]    <= enq_old_prd1;
            entry_need_to_wb[enq_ptr_p1] <= enq_need_to_wb1;
        end
        if (head_ready) begin
            commit_need_to_wb <= entry_need_to_wb[deq_ptr];
            commit_lrd        <= entry_lrd[deq_ptr];
            commit_prd        <= entry_prd[deq_ptr];
            commit_old_prd    <= entry_old_prd[deq_ptr];
        end
    end

    // walk pair, slot 0 younger, non-writers masked off
    assign walking_valid0   = (state == walk_walk) && (walk_left != '0)
                              && entry_need_to_wb[walk_ptr];
    assign walking_valid1   = (state == walk_walk) && (walk_left > rob_id_w'(1))
                              && entry_need_to_wb[walk_ptr_m1];
    assign walking_lrd0     = entry_lrd[walk_ptr];
    assign walking_lrd1     = entry_lrd[walk_ptr_m1];
    assign walking_prd0     = entry_prd[walk_ptr];
    assign walking_prd1     = entry_prd[walk_ptr_m1];
    assign walking_old_prd0 = entry_old_prd[walk_ptr];
    assign walking_old_prd1 = entry_old_prd[walk_ptr_m1];

    // completion only for live entries
    assert property (@(posedge clock) disable iff (!reset_n)
        (complete_wren0 |-> entry_valid[complete_wraddr0])
        and (complete_wren1 |-> entry_valid[complete_wraddr1]));
    // flush target must be in flight, head included
    assert property (@(posedge clock) disable iff (!reset_n)
        (flush_valid && is_idle) |-> (rob_id_w'(flush_id - head_id) < rob_instr_cnt));

endmodule

//--- hw/spec_rat.sv
`timescale 1ns/1ps

module spec_rat import ooo_pkg::*; (
    input  logic              clock,
    input  logic              reset_n,
    input  logic [lreg_w-1:0] map_lrd0,
    input  logic [lreg_w-1:0] map_lrd1,
    input  logic              rename_wen0,
    input  logic              rename_wen1,
    input  logic [preg_w-1:0] rename_prd0,
    input  logic [preg_w-1:0] rename_prd1,
    input  logic              walk_wen0,
    input  logic [lreg_w-1:0] walk_lrd0,
    input  logic [preg_w-1:0] walk_old_prd0,
    input  logic              walk_wen1,
    input  logic [lreg_w-1:0] walk_lrd1,
    input  logic [preg_w-1:0] walk_old_prd1,
    output logic [preg_w-1:0] map_prd0,
    output logic [preg_w-1:0] map_prd1
);

    // speculative logical to physical map
    logic [preg_w-1:0] map_table [num_lreg];

    // read ports, old mapping before this cycle's writes
    assign map_prd0 = map_table[map_lrd0];
    assign map_prd1 = map_table[map_lrd1];

    // --------------------------------------------------
    // rename writes and walk restores
    // --------------------------------------------------
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            // identity map out of reset
            for (int i = 0; i < num_lreg; i++) begin
                map_table[i] <= preg_w'(i);
            end
        end else begin
            // program order, slot 1 is younger and wins
            if (rename_wen0) begin
                map_table[map_lrd0] <= rename_prd0;
            end
            if (rename_wen1) begin
                map_table[map_lrd1] <= rename_prd1;
            end
            // walk goes backward, slot 1 is the older entry
            // its old mapping is the one that must survive
            if (walk_wen0) begin
                map_table[walk_lrd0] <= walk_old_prd0;
            end
            if (walk_wen1) begin
                map_table[walk_lrd1] <= walk_old_prd1;
            end
        end
    end

    // dispatch is held off for the whole flush sequence
    assert property (@(posedge clock) disable iff (!reset_n)
        (rename_wen0 || rename_wen1) |-> !(walk_wen0 || walk_wen1));

endmodule

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log build.log &&
verilator --binary --timing --assert --top-module tb_rename_retire -f compile.f -o sim_tb \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- verification/rob_cases.txt
# test name | disp v0 lrd0 wb0 v1 lrd1 wb1 | nop pairs | block lrd0 lrd1 | complete en0 i0 en1 i1
# flush id | idle | quiet cycles | retire wb lrd prd old_prd | state cnt id ready idle (hex)
test reset_state
state 00 00 1 1
quiet 2
test rename_pairs
disp 1 01 1 1 02 1
disp 1 03 1 1 03 1
state 04 04 1 1
test ooo_commit
complete 1 03 1 01
quiet 3
complete 0 00 1 02
quiet 2
complete 1 00 0 00
retire 1 01 20 01
retire 1 02 21 02
retire 1 03 22 03
retire 1 03 23 22
state 00 04 1 1
test flush_walk
disp 1 05 1 1 01 1
disp 1 05 1 1 07 0
disp 1 01 1 1 06 1
state 06 0a 1 1
flush 05
idle
state 02 06 1 1
test post_flush_rename
disp 1 01 1 1 05 1
state 04 08 1 1
complete 1 05 1 06
complete 1 07 0 00
quiet 2
complete 1 04 0 00
retire 1 05 01 05
retire 1 01 02 20
retire 1 01 03 02
retire 1 05 22 01
state 00 08 1 1
test old_prd_reuse
disp 1 02 1 1 09 1
complete 1 08 1 09
retire 1 02 01 21
retire 1 09 02 09
state 00 0a 1 1
test back_pressure
nop 20
state 40 4a 0 1
block 04 04
state 40 4a 0 1

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic reset_n
);

    // 4 ns period, first rising edge at 2 ns
    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // held over two rising edges, released on a falling edge
    initial begin
        reset_n = 1'b0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

//--- verification/tb_rename_retire.sv
`timescale 1ns/1ps

module tb_rename_retire import ooo_pkg::*; ();

    localparam string cases_file = "verification/rob_cases.txt";
    localparam int    wait_limit = 300;
    // which level a wait loop watches
    localparam int    sel_ready  = 0;
    localparam int    sel_idle   = 1;
    localparam int    sel_commit = 2;

    logic                  clock, reset_n;
    logic                  disp_valid0, disp_valid1, disp_need_to_wb0, disp_need_to_wb1;
    logic [lreg_w-1:0]     disp_lrd0, disp_lrd1;
    logic                  complete_wren0, complete_wren1;
    logic [rob_addr_w-1:0] complete_wraddr0, complete_wraddr1;
    logic                  flush_valid;
    logic [rob_id_w-1:0]   flush_id;
    logic                  dispatch_ready, commit_valid, commit_need_to_wb, is_idle;
    logic [lreg_w-1:0]     commit_lrd;
    logic [preg_w-1:0]     commit_prd, commit_old_prd;
    logic [rob_id_w-1:0]   rob_instr_cnt, rob_instr_id;

    // case file parsing
    int              fd, last, waited;
    int              f0, f1, f2, f3, f4, f5;
    string           line;
    logic [7:0]      cmd;
    logic [8*16-1:0] word;

    // bookkeeping
    string test_name = "setup";
    bit    test_open = 1'b0;
    bit    run_aborted = 1'b0;
    int    test_errors = 0;
    int    error_count = 0;
    int    check_count = 0;
    int    test_count = 0;

    tb_clock_gen clock_gen_inst (.clock(clock), .reset_n(reset_n));

    rename_retire_top rename_retire_top_inst (.*);

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic check_value(input string what, input int expected, input int actual);
        check_count++;
        assert (expected == actual) else begin
            $display("Fail %0s %0s: expected %0h, actual %0h", test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    function automatic logic level_of(input int which);
        case (which)
            sel_ready: level_of = dispatch_ready;
            sel_idle:  level_of = is_idle;
            default:   level_of = commit_valid;
        endcase
    endfunction

    // polled on falling edges
    task automatic wait_level(input int which, input string label);
        int count;
        count = 0;
        while (!level_of(which) && count < wait_limit) begin
            @(negedge clock);
            count++;
        end
        if (!level_of(which)) begin
            $display("Timeout in test %0s: %0s never went high", test_name, label);
            test_errors++;
            run_aborted = 1'b1;
        end
    endtask

    // pair held for exactly one cycle
    task automatic offer_pair(input logic v0, input logic [lreg_w-1:0] l0, input logic w0,
                              input logic v1, input logic [lreg_w-1:0] l1, input logic w1);
        disp_valid0      = v0;
        disp_lrd0        = l0;
        disp_need_to_wb0 = w0;
        disp_valid1      = v1;
        disp_lrd1        = l1;
        disp_need_to_wb1 = w1;
        @(negedge clock);
        disp_valid1 = 1'b0;
        disp_valid0 = 1'b0;
    endtask

    task automatic close_test();
        if (test_open) begin
            if (test_errors == 0) begin
                $display("test %0s: ok", test_name);
            end else begin
                $display("test %0s: %0d errors", test_name, test_errors);
            end
            error_count += test_errors;
        end
        test_open = 1'b0;
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        disp_valid0 = 1'b0;
        disp_valid1 = 1'b0;
        disp_lrd0 = '0;
        disp_lrd1 = '0;
        disp_need_to_wb0 = 1'b0;
        disp_need_to_wb1 = 1'b0;
        complete_wren0 = 1'b0;
        complete_wren1 = 1'b0;
        complete_wraddr0 = '0;
        complete_wraddr1 = '0;
        flush_valid = 1'b0;
        flush_id = '0;
        f0 = 0;
        f1 = 0;
        f2 = 0;
        f3 = 0;
        f4 = 0;
        f5 = 0;

        waited = 0;
        while (reset_n !== 1'b1 && waited < wait_limit) begin
            @(posedge clock);
            waited++;
        end
        if (reset_n !== 1'b1) begin
            $display("Timeout: reset was never released");
            run_aborted = 1'b1;
        end
        @(negedge clock);

        fd = $fopen(cases_file, "r");
        if (fd == 0) begin
            $display("Could not open the case file %0s", cases_file);
            run_aborted = 1'b1;
        end

        // command picked by the first character
        while (!run_aborted && $fgets(line, fd) > 0) begin
            cmd = line.getc(0);
            void'($sscanf(line, "%s %h %h %h %h %h %h", word, f0, f1, f2, f3, f4, f5));
            case (cmd)
                "t": begin
                    close_test();
                    last = line.len() - 1;
                    while (last > 5 && line.getc(last) < 8'h21) begin
                        last--;
                    end
                    test_name = line.substr(5, last);
                    test_open = 1'b1;
                    test_errors = 0;
                    test_count++;
                end
                "d": begin
                    wait_level(sel_ready, "dispatch_ready");
                    if (!run_aborted) begin
                        offer_pair(f0[0], f1[lreg_w-1:0], f2[0], f3[0], f4[lreg_w-1:0], f5[0]);
                    end
                end
                // non-writing pairs to fill the rob
                "n": begin
                    for (int i = 0; i < f0 && !run_aborted; i++) begin
                        wait_level(sel_ready, "dispatch_ready");
                        if (!run_aborted) begin
                            offer_pair(1'b1, '0, 1'b0, 1'b1, '0, 1'b0);
                        end
                    end
                end
                // pair offered against a low ready
                "b": begin
                    check_value("dispatch_ready", 0, int'(dispatch_ready));
                    offer_pair(1'b1, f0[lreg_w-1:0], 1'b1, 1'b1, f1[lreg_w-1:0], 1'b1);
                end
                "c": begin
                    complete_wren0   = f0[0];
                    complete_wraddr0 = f1[rob_addr_w-1:0];
                    complete_wren1   = f2[0];
                    complete_wraddr1 = f3[rob_addr_w-1:0];
                    @(negedge clock);
                    complete_wren0 = 1'b0;
                    complete_wren1 = 1'b0;
                end
                "f": begin
                    wait_level(sel_idle, "is_idle");
                    if (!run_aborted) begin
                        flush_valid = 1'b1;
                        flush_id    = f0[rob_id_w-1:0];
                        @(negedge clock);
                        flush_valid = 1'b0;
                    end
                end
                "i": wait_level(sel_idle, "is_idle");
                "q": begin
                    for (int i = 0; i < f0; i++) begin
                        check_value("commit_valid", 0, int'(commit_valid));
                        @(negedge clock);
                    end
                end
                // next commit in id order
                // prd fields compared for writers only
                "r": begin
                    wait_level(sel_commit, "commit_valid");
                    if (!run_aborted) begin
                        check_value("commit_need_to_wb", f0, int'(commit_need_to_wb));
                        check_value("commit_lrd", f1, int'(commit_lrd));
                        if (f0 != 0) begin
                            check_value("commit_prd", f2, int'(commit_prd));
                            check_value("commit_old_prd", f3, int'(commit_old_prd));
                        end
                        @(negedge clock);
                    end
                end
                "s": begin
                    check_value("rob_instr_cnt", f0, int'(rob_instr_cnt));
                    check_value("rob_instr_id", f1, int'(rob_instr_id));
                    check_value("dispatch_ready", f2, int'(dispatch_ready));
                    check_value("is_idle", f3, int'(is_idle));
                end
                default: begin
                end
            endcase
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        close_test();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0 && !run_aborted) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
